// File: list.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/regfile.sv
verilog/forward.sv
verilog/hazard.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/writeback.sv
verilog/cpu.sv
verif/cpu_tb.sv

// File: verif/cpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU testbench
// Random RV32I subset programs run through the core and a
// sequential ISA model, retire records compared in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpu_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int WAIT_LIMIT = 200;           // Longest any single wait may last in cycles

    logic    clk;
    logic    rst_n;
    logic    inst_valid;
    logic    inst_ready;
    inst_t   inst;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire;

    word_t   model_regs [32];                  // Architectural state of the ISA model
    word_t   model_mem [DMEM_WORDS];
    retire_t exp_q [$];                        // Accepted but not yet retired
    word_t   prog [$];                         // Program of the running test
    string   cur_test = "reset";
    int      stall_pct = 0;                    // Chance of retire_ready low per cycle
    int      errors = 0;
    int      sent = 0;
    int      retired = 0;
    int      tests = 0;
    logic    stuck = 1'b0;                     // A wait timed out, stop sending

    cpu u_dut (.clk, .rst_n, .inst_valid, .inst_ready, .inst,
               .retire_valid, .retire_ready, .retire);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t r_type_word(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                          reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    // ADDI or LW depending on the opcode
    function automatic word_t i_type_word(logic [6:0] op, reg_addr_t rd, reg_addr_t rs1,
                                          logic [11:0] imm);
        return {imm, rs1, (op == OP_LOAD) ? F3_LW : F3_ADD, rd, op};
    endfunction

    function automatic word_t store_word(reg_addr_t rs1, reg_addr_t rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_LW, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t lui_word(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    // Low registers most of the time so that results get reused
    function automatic reg_addr_t pick_reg();
        if ($urandom % 4 != 0)
            return reg_addr_t'($urandom % 8);
        return reg_addr_t'($urandom % 32);
    endfunction

    // Kinds 0-5 R-type, 6 ADDI, 7 LUI, 8 LW, 9 SW, others an illegal word
    function automatic word_t random_inst(int kind, reg_addr_t rd, reg_addr_t rs1,
                                          reg_addr_t rs2);
        word_t w;
        w = $urandom;
        case (kind)
            0: return r_type_word(7'b0, F3_ADD, rd, rs1, rs2);
            1: return r_type_word(F7_SUB, F3_ADD, rd, rs1, rs2);
            2: return r_type_word(7'b0, F3_AND, rd, rs1, rs2);
            3: return r_type_word(7'b0, F3_OR, rd, rs1, rs2);
            4: return r_type_word(7'b0, F3_XOR, rd, rs1, rs2);
            5: return r_type_word(7'b0, F3_SLT, rd, rs1, rs2);
            6: return i_type_word(OP_IMM, rd, rs1, w[11:0]);
            7: return lui_word(rd, w[19:0]);
            8: return i_type_word(OP_LOAD, rd, rs1, w[11:0] & 12'hffc);
            9: return store_word(rs1, rs2, w[11:0] & 12'hffc);
            default: begin
                if (w[31])
                    w[6:0] = 7'b1100011;                        // Branch opcode
                else if (w[30])
                    w = {w[31:15], 3'b001, w[11:7], OP_IMM};    // SLLI
                else
                    w = {w[31:15], 3'b000, w[11:7], OP_LOAD};   // LB
                return w;
            end
        endcase
    endfunction

    // Executes one accepted word in program order and queues its retire record
    task automatic model_step(input word_t w);
        logic [6:0] op;
        logic [6:0] f7;
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      addr;
        word_t      res;
        logic       legal;
        retire_t    exp;
        op    = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        rd    = w[11:7];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm   = {{20{w[31]}}, w[31:20]};       // I-type immediate
        res   = '0;
        legal = 1'b1;
        exp   = '0;
        case (op)
            OP_REG: begin
                if (f7 == F7_SUB && f3 == F3_ADD)
                    res = a - b;
                else if (f7 != 7'b0)
                    legal = 1'b0;
                else if (f3 == F3_ADD)
                    res = a + b;
                else if (f3 == F3_SLT)
                    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                else if (f3 == F3_XOR)
                    res = a ^ b;
                else if (f3 == F3_OR)
                    res = a | b;
                else if (f3 == F3_AND)
                    res = a & b;
                else
                    legal = 1'b0;              // Shifts and SLTU
            end
            OP_IMM: begin
                legal = f3 == F3_ADD;
                res   = a + imm;
            end
            OP_LUI: res = {w[31:12], 12'h000};
            OP_LOAD: begin
                addr  = a + imm;
                legal = f3 == F3_LW;
                res   = model_mem[addr[7:2]];  // Only word index bits matter
            end
            OP_STORE: begin
                imm   = {{20{w[31]}}, w[31:25], w[11:7]};   // S-type immediate
                addr  = a + imm;
                legal = f3 == F3_LW;
                if (legal)
                    model_mem[addr[7:2]] = b;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            exp.illegal = 1'b1;                // Zero data and no register write
        end else if (op == OP_STORE) begin
            exp.data = b;                      // Store retires its data, rd_we low
        end else begin
            exp.data  = res;
            exp.rd    = rd;
            exp.rd_we = 1'b1;                  // Also for x0, which stays zero
            if (rd != '0)
                model_regs[rd] = res;
        end
        exp_q.push_back(exp);
        sent++;
    endtask

    // One retire record as readable fields
    function automatic string retire_text(input retire_t r);
        return $sformatf("data %h rd %0d rd_we %b illegal %b", r.data, r.rd, r.rd_we, r.illegal);
    endfunction

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %s, actual %s", name, retire_text(exp),
                     retire_text(act));
            errors++;
        end
    endtask

    // Offers one word with random idle gaps in front, returns after the handshake
    task automatic send_inst(input word_t w, input int gap_pct);
        int waited;
        if (stuck)
            return;
        while (($urandom % 100) < gap_pct) begin
            inst_valid = 1'b0;
            inst       = $urandom;             // Junk on the bus while idle
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b1;
        inst       = w;
        waited     = 0;
        @(negedge clk);
        while (!inst_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!inst_ready) begin
            $display("test %s: inst_ready stayed low for %0d cycles", cur_test, WAIT_LIMIT);
            errors++;
            stuck = 1'b1;
        end else begin
            @(posedge clk);                    // Accepted on this edge
            model_step(w);
            #1;
            inst_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("test %s: %0d instructions never reached retire", cur_test, exp_q.size());
            errors++;
            stuck = 1'b1;
            exp_q.delete();
        end
    endtask

    task automatic run_test(input string name, input int gap_pct, input int stall);
        int errs_before;
        errs_before = errors;
        cur_test    = name;
        stall_pct   = stall;
        foreach (prog[i])
            send_inst(prog[i], gap_pct);
        drain();
        stall_pct = 0;
        tests++;
        $display("test %-12s %0d instructions, %0d errors", name, prog.size(),
                 errors - errs_before);
    endtask

    task automatic drive_retire_ready();
        forever begin
            @(posedge clk);
            #1;
            retire_ready = ($urandom % 100) >= stall_pct;
        end
    endtask

    // Sampled half a cycle ahead of the edge that completes the handshake
    always @(negedge clk) begin
        retire_t exp;
        if (rst_n && retire_valid && retire_ready) begin
            retired++;
            if (exp_q.size() == 0) begin
                $display("test %s: retire with no instruction outstanding", cur_test);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                check_retire(cur_test, exp, retire);
            end
        end
    end

    initial begin
        reg_addr_t   prev;
        reg_addr_t   nxt;
        reg_addr_t   base;
        logic [11:0] off;
        void'($urandom(32'h18a77b32));
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        retire_ready = 1'b1;
        foreach (model_regs[i])
            model_regs[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            drive_retire_ready();
        join_none
        @(negedge clk);
        if (!inst_ready || retire_valid) begin
            $display("after reset inst_ready is %b and retire_valid is %b",
                     inst_ready, retire_valid);
            errors++;
        end
        @(posedge clk);
        #1;

        prog.delete();                         // Every RAM word gets a known value
        for (int i = 0; i < DMEM_WORDS; i++) begin
            prog.push_back(lui_word(5'd1, 20'($urandom)));
            prog.push_back(i_type_word(OP_IMM, 5'd1, 5'd1, 12'($urandom)));
            prog.push_back(store_word(5'd0, 5'd1, 12'(i * 4)));
        end
        run_test("mem_fill", 0, 0);

        prog.delete();
        for (int i = 0; i < 60; i++)
            prog.push_back(random_inst($urandom % 8, reg_addr_t'(1 + $urandom % 31),
                                       reg_addr_t'($urandom % 32),
                                       reg_addr_t'($urandom % 32)));
        run_test("alu", 0, 0);

        prog.delete();
        prev = 5'd1;
        for (int i = 0; i < 60; i++) begin
            nxt = reg_addr_t'(1 + $urandom % 7);
            prog.push_back(random_inst($urandom % 8, nxt, prev, pick_reg()));
            prev = nxt;                        // Next one reads this result
        end
        run_test("forward", 0, 0);

        prog.delete();
        for (int i = 0; i < 30; i++) begin
            nxt = reg_addr_t'(1 + $urandom % 7);
            prog.push_back(random_inst(8, nxt, pick_reg(), 5'd0));
            if ($urandom % 2)
                prog.push_back(random_inst($urandom % 7, pick_reg(), nxt, pick_reg()));
            else
                prog.push_back(random_inst($urandom % 6, pick_reg(), pick_reg(), nxt));
        end
        run_test("load_use", 0, 0);

        prog.delete();
        for (int i = 0; i < 30; i++) begin
            base = pick_reg();
            off  = 12'(($urandom % DMEM_WORDS) * 4);
            prog.push_back(store_word(base, pick_reg(), off));
            if ($urandom % 2)
                off = 12'(($urandom % DMEM_WORDS) * 4);   // Half the time another word
            prog.push_back(i_type_word(OP_LOAD, reg_addr_t'(1 + $urandom % 7), base, off));
        end
        run_test("store_load", 0, 0);

        prog.delete();
        for (int i = 0; i < 40; i++) begin
            case ($urandom % 3)
                0: prog.push_back(random_inst(10, 5'd0, 5'd0, 5'd0));
                1: prog.push_back(random_inst($urandom % 9, 5'd0, pick_reg(), pick_reg()));
                default: prog.push_back(random_inst($urandom % 6, pick_reg(), 5'd0, pick_reg()));
            endcase
        end
        run_test("illegal_x0", 0, 0);

        prog.delete();
        for (int i = 0; i < 400; i++)
            prog.push_back(random_inst($urandom % 11, pick_reg(), pick_reg(), pick_reg()));
        run_test("backpressure", 30, 40);

        if (retired != sent) begin
            $display("%0d instructions were accepted but %0d retired", sent, retired);
            errors++;
        end
        $display("%0d tests, %0d instructions, %0d retired, %0d errors",
                 tests, sent, retired, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU top
// Four-stage in-order RV32I subset core with forwarding and
// load-use stall between instruction and retire streams
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    output logic              inst_ready,
    input  isa_pkg::inst_t    inst,
    output logic              retire_valid,
    input  logic              retire_ready,
    output pipe_pkg::retire_t retire
);
    import isa_pkg::*;
    import pipe_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    rs_sel_t   rs1_sel;
    rs_sel_t   rs2_sel;
    logic      uses_rs2;
    logic      bubble;
    word_t     alu_data;                       // Bypass from execute
    word_t     mem_data;                       // Bypass from memory
    logic      rd_we;
    reg_addr_t rd_addr;
    word_t     rd_data;

    logic      ex_valid;
    logic      ex_ready;
    ex_t       ex_q;
    logic      mm_valid;
    logic      mm_ready;
    mm_t       mm_q;
    logic      wb_valid;
    logic      wb_ready;
    wb_t       wb_q;

    regfile u_regfile (.clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
                       .rd_we, .rd_addr, .rd_data);

    forward u_forward (.rs1_addr, .rs2_addr, .ex_q, .ex_valid, .mm_q, .mm_valid,
                       .wb_q, .wb_valid, .rs1_sel, .rs2_sel);

    hazard u_hazard (.rs1_addr, .rs2_addr, .uses_rs2, .ex_q, .ex_valid, .bubble);

    decode u_decode (.clk, .rst_n, .inst_valid, .inst_ready, .inst, .rs1_sel, .rs2_sel,
                     .rs1_data, .rs2_data, .alu_data, .mem_data, .wb_data(wb_q.data),
                     .rs1_addr, .rs2_addr, .uses_rs2, .bubble, .ex_valid, .ex_ready, .ex_q);

    execute u_execute (.clk, .rst_n, .ex_valid, .ex_ready, .ex_q, .alu_data,
                       .mm_valid, .mm_ready, .mm_q);

    memory u_memory (.clk, .rst_n, .mm_valid, .mm_ready, .mm_q, .mem_data,
                     .wb_valid, .wb_ready, .wb_q);

    writeback u_writeback (.wb_valid, .wb_ready, .wb_q, .retire_valid, .retire_ready,
                           .retire, .rd_we, .rd_addr, .rd_data);

endmodule

// File: verilog/decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// Splits the instruction word, builds immediates, selects the
// forwarded operands and loads the execute register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    output logic               inst_ready,
    input  isa_pkg::inst_t     inst,
    input  pipe_pkg::rs_sel_t  rs1_sel,
    input  pipe_pkg::rs_sel_t  rs2_sel,
    input  isa_pkg::word_t     rs1_data,
    input  isa_pkg::word_t     rs2_data,
    input  isa_pkg::word_t     alu_data,
    input  isa_pkg::word_t     mem_data,
    input  isa_pkg::word_t     wb_data,
    output isa_pkg::reg_addr_t rs1_addr,
    output isa_pkg::reg_addr_t rs2_addr,
    output logic               uses_rs2,
    input  logic               bubble,
    output logic               ex_valid,
    input  logic               ex_ready,
    output pipe_pkg::ex_t      ex_q
);
    import isa_pkg::*;
    import pipe_pkg::*;

    ex_t   ex_d;
    word_t rs1_val;
    word_t rs2_val;
    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    logic  load_en;

    assign rs1_addr = inst.r_fmt.rs1;          // Same position in every format
    assign rs2_addr = inst.r_fmt.rs2;
    assign uses_rs2 = inst.r_fmt.opcode == OP_REG || inst.r_fmt.opcode == OP_STORE;

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_u = {inst.i_fmt.imm, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'h000};   // LUI

    function automatic word_t operand(rs_sel_t sel, word_t reg_val);
        case (sel)
            SEL_ALU: return alu_data;
            SEL_MEM: return mem_data;
            SEL_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        rs1_val = operand(rs1_sel, rs1_data);
        rs2_val = operand(rs2_sel, rs2_data);
    end

    always_comb begin
        ex_d            = '0;
        ex_d.alu_op     = ALU_ADD;             // Loads and stores add the offset
        ex_d.a          = rs1_val;
        ex_d.b          = rs2_val;
        ex_d.store_data = rs2_val;
        ex_d.illegal    = 1'b1;                // Cleared by a supported encoding
        case (inst.r_fmt.opcode)
            OP_REG: begin
                ex_d.illegal = !(inst.r_fmt.funct7 == '0 ||
                                 (inst.r_fmt.funct7 == F7_SUB && inst.r_fmt.funct3 == F3_ADD));
                case (inst.r_fmt.funct3)
                    F3_ADD:  ex_d.alu_op = (inst.r_fmt.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:  ex_d.alu_op = ALU_SLT;
                    F3_XOR:  ex_d.alu_op = ALU_XOR;
                    F3_OR:   ex_d.alu_op = ALU_OR;
                    F3_AND:  ex_d.alu_op = ALU_AND;
                    default: ex_d.illegal = 1'b1;   // Shifts and SLTU
                endcase
            end
            OP_IMM: begin
                ex_d.b       = imm_i;
                ex_d.illegal = inst.i_fmt.funct3 != F3_ADD;
            end
            OP_LUI: begin
                ex_d.alu_op  = ALU_PASS_B;
                ex_d.b       = imm_u;
                ex_d.illegal = 1'b0;
            end
            OP_LOAD: begin
                ex_d.b       = imm_i;
                ex_d.is_load = 1'b1;
                ex_d.illegal = inst.i_fmt.funct3 != F3_LW;   // Word loads only
            end
            OP_STORE: begin
                ex_d.b        = imm_s;
                ex_d.is_store = 1'b1;
                ex_d.illegal  = inst.s_fmt.funct3 != F3_LW;
            end
            default: ;
        endcase
        if (ex_d.illegal) begin
            ex_d.alu_op   = ALU_PASS_B;        // Illegal words retire with zero data
            ex_d.b        = '0;
            ex_d.is_load  = 1'b0;
            ex_d.is_store = 1'b0;
        end
        ex_d.rd_we = !ex_d.illegal && !ex_d.is_store;
        ex_d.rd    = ex_d.rd_we ? inst.r_fmt.rd : '0;   // No destination without a write
    end

    // Bubble keeps the word at the input while the load moves on
    assign inst_ready = (!ex_valid || ex_ready) && !bubble;
    assign load_en    = inst_valid && inst_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (!ex_valid || ex_ready) begin
            ex_valid <= load_en;               // Empty slot on a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            ex_q <= ex_d;
        end
    end

endmodule

// File: verilog/execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// ALU and address adder, result bypass and the memory register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module execute (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ex_valid,
    output logic           ex_ready,
    input  pipe_pkg::ex_t  ex_q,
    output isa_pkg::word_t alu_data,
    output logic           mm_valid,
    input  logic           mm_ready,
    output pipe_pkg::mm_t  mm_q
);
    import pipe_pkg::*;

    mm_t  mm_d;
    logic move;

    always_comb begin
        case (ex_q.alu_op)
            ALU_SUB:    alu_data = ex_q.a - ex_q.b;
            ALU_AND:    alu_data = ex_q.a & ex_q.b;
            ALU_OR:     alu_data = ex_q.a | ex_q.b;
            ALU_XOR:    alu_data = ex_q.a ^ ex_q.b;
            ALU_SLT:    alu_data = {31'b0, $signed(ex_q.a) < $signed(ex_q.b)};
            ALU_PASS_B: alu_data = ex_q.b;
            default:    alu_data = ex_q.a + ex_q.b;   // ADD and the load/store address
        endcase
    end

    assign mm_d = '{
        alu:        alu_data,
        store_data: ex_q.store_data,
        rd:         ex_q.rd,
        rd_we:      ex_q.rd_we,
        is_load:    ex_q.is_load,
        is_store:   ex_q.is_store,
        illegal:    ex_q.illegal
    };

    assign ex_ready = !mm_valid || mm_ready;   // Empty or draining this cycle
    assign move     = ex_valid && ex_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_valid <= 1'b0;
        end else if (ex_ready) begin
            mm_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            mm_q <= mm_d;
        end
    end

endmodule

// File: verilog/forward.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Forwarding unit
// Picks the youngest in-flight producer of each decode source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module forward (
    input  isa_pkg::reg_addr_t rs1_addr,
    input  isa_pkg::reg_addr_t rs2_addr,
    input  pipe_pkg::ex_t      ex_q,
    input  logic               ex_valid,
    input  pipe_pkg::mm_t      mm_q,
    input  logic               mm_valid,
    input  pipe_pkg::wb_t      wb_q,
    input  logic               wb_valid,
    output pipe_pkg::rs_sel_t  rs1_sel,
    output pipe_pkg::rs_sel_t  rs2_sel
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // Execute holds the youngest result so it is checked first
    function automatic rs_sel_t pick(reg_addr_t addr);
        if (addr == '0)
            return SEL_REG;                    // x0 never forwards
        if (ex_valid && ex_q.rd_we && ex_q.rd == addr)
            return SEL_ALU;
        if (mm_valid && mm_q.rd_we && mm_q.rd == addr)
            return SEL_MEM;
        if (wb_valid && wb_q.rd_we && wb_q.rd == addr)
            return SEL_WB;
        return SEL_REG;
    endfunction

    always_comb begin
        rs1_sel = pick(rs1_addr);
        rs2_sel = pick(rs2_addr);
    end

endmodule

// File: verilog/hazard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard unit
// Holds decode for one cycle when it reads a load in execute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module hazard (
    input  isa_pkg::reg_addr_t rs1_addr,
    input  isa_pkg::reg_addr_t rs2_addr,
    input  logic               uses_rs2,
    input  pipe_pkg::ex_t      ex_q,
    input  logic               ex_valid,
    output logic               bubble
);
    logic load_in_ex;
    logic rs1_hit;
    logic rs2_hit;

    assign load_in_ex = ex_valid && ex_q.is_load && ex_q.rd != '0;   // Load data not ready yet
    assign rs1_hit    = ex_q.rd == rs1_addr;
    assign rs2_hit    = uses_rs2 && ex_q.rd == rs2_addr;            // Only R and S formats read rs2

    // The load reaches memory next cycle where SEL_MEM can supply it
    assign bubble = load_in_ex && (rs1_hit || rs2_hit);

endmodule

// File: verilog/isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ISA package
// Word and register types, the instruction word union and the
// RV32I opcode and function codes used by the core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package isa_pkg;

    typedef logic [31:0] word_t;               // Data and instruction word
    typedef logic [4:0]  reg_addr_t;           // Register index

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Immediate and load format
    typedef struct packed {
        logic [11:0] imm;                      // Sign extended by decode
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Store format
    typedef struct packed {
        logic [6:0] imm_hi;                    // Offset bits 11 to 5
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                    // Offset bits 4 to 0
        logic [6:0] opcode;
    } s_fmt_t;

    // One instruction word seen through each format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_t;

    localparam logic [6:0] OP_REG   = 7'b0110011;   // ADD SUB AND OR XOR SLT
    localparam logic [6:0] OP_IMM   = 7'b0010011;   // Only ADDI is supported
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD = 3'b000;          // Also ADDI and SUB
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;          // Word width for both LW and SW

    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

// File: verilog/memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage
// Word-wide data RAM for LW and SW, memory bypass and the
// writeback register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module memory (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           mm_valid,
    output logic           mm_ready,
    input  pipe_pkg::mm_t  mm_q,
    output isa_pkg::word_t mem_data,
    output logic           wb_valid,
    input  logic           wb_ready,
    output pipe_pkg::wb_t  wb_q
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t              ram [DMEM_WORDS];
    logic [DMEM_AW-1:0] index;
    logic               move;

    assign index = mm_q.alu[2 +: DMEM_AW];     // Address bits 7 to 2 select the word

    // Loads read the RAM here so the bypass sees the loaded word
    always_comb begin
        if (mm_q.is_load)
            mem_data = ram[index];
        else if (mm_q.is_store)
            mem_data = mm_q.store_data;        // Stores retire with their data
        else
            mem_data = mm_q.alu;
    end

    assign mm_ready = !wb_valid || wb_ready;
    assign move     = mm_valid && mm_ready;

    always_ff @(posedge clk) begin
        if (move && mm_q.is_store) begin
            ram[index] <= mm_q.store_data;     // Written as the store leaves
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (mm_ready) begin
            wb_valid <= mm_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            wb_q <= '{data: mem_data, rd: mm_q.rd, rd_we: mm_q.rd_we, illegal: mm_q.illegal};
        end
    end

endmodule

// File: verilog/pipe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline package
// Stage payloads, ALU and operand select codes and the size
// of the data RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                               // Signed compare
        ALU_PASS_B                             // Operand b straight through
    } alu_op_t;

    // Source of a decode operand
    typedef enum logic [1:0] {
        SEL_REG,                               // Register file
        SEL_ALU,                               // Execute register result
        SEL_MEM,                               // Memory register result
        SEL_WB                                 // Writeback register data
    } rs_sel_t;

    // Decode to execute
    typedef struct packed {
        alu_op_t           alu_op;
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        isa_pkg::word_t    store_data;
        isa_pkg::reg_addr_t rd;
        logic              rd_we;
        logic              is_load;
        logic              is_store;
        logic              illegal;
    } ex_t;

    // Execute to memory
    typedef struct packed {
        isa_pkg::word_t    alu;                // Result or load/store address
        isa_pkg::word_t    store_data;
        isa_pkg::reg_addr_t rd;
        logic              rd_we;
        logic              is_load;
        logic              is_store;
        logic              illegal;
    } mm_t;

    // Memory to writeback
    typedef struct packed {
        isa_pkg::word_t    data;
        isa_pkg::reg_addr_t rd;
        logic              rd_we;
        logic              illegal;
    } wb_t;

    // Record seen on the retire stream
    typedef struct packed {
        isa_pkg::word_t    data;
        isa_pkg::reg_addr_t rd;
        logic              rd_we;
        logic              illegal;
    } retire_t;

    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);   // Word index width

endpackage

// File: verilog/regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
// Thirty-one registers with two write-first reads, x0 is zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::reg_addr_t rs1_addr,
    input  isa_pkg::reg_addr_t rs2_addr,
    output isa_pkg::word_t     rs1_data,
    output isa_pkg::word_t     rs2_data,
    input  logic               rd_we,
    input  isa_pkg::reg_addr_t rd_addr,
    input  isa_pkg::word_t     rd_data
);
    import isa_pkg::*;

    word_t regs [1:31];                        // No storage behind x0

    // A write to the same index is seen in the same cycle
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (rd_we && rd_addr == addr)
            return rd_data;
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;          // Writes to x0 are dropped
        end
    end

endmodule

// File: verilog/writeback.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writeback stage
// Drives the retire stream and the register file write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module writeback (
    input  logic               wb_valid,
    output logic               wb_ready,
    input  pipe_pkg::wb_t      wb_q,
    output logic               retire_valid,
    input  logic               retire_ready,
    output pipe_pkg::retire_t  retire,
    output logic               rd_we,
    output isa_pkg::reg_addr_t rd_addr,
    output isa_pkg::word_t     rd_data
);
    logic retire_done;

    assign retire_valid = wb_valid;
    assign wb_ready     = retire_ready;        // Retire stall backs up every stage
    assign retire       = '{data: wb_q.data, rd: wb_q.rd, rd_we: wb_q.rd_we,
                            illegal: wb_q.illegal};

    assign retire_done = wb_valid && retire_ready;

    // The register changes only once the outside has taken the record
    assign rd_we   = retire_done && wb_q.rd_we && wb_q.rd != '0;
    assign rd_addr = wb_q.rd;
    assign rd_data = wb_q.data;

endmodule
